// File: osd_params.svh
`ifndef OSD_PARAMS_SVH
`define OSD_PARAMS_SVH

// identity reported through the base registers
`define OSD_MODID         16'h0001
`define OSD_MODVERSION    16'h0000
`define OSD_CAN_STALL     1'b1

// local register map
`define OSD_REG_MODID     16'h0000
`define OSD_REG_VERSION   16'h0001
`define OSD_REG_CS        16'h0003
`define OSD_CS_STALL      5'h01       // command in data[15:11] of a CS write

// extension bank, everything from here up goes to the register port
`define OSD_EXT_BASE      16'h0200
`define OSD_REG_SCRATCH0  16'h0200
`define OSD_REG_SCRATCH1  16'h0201
`define OSD_REG_SYSRST    16'h0202
`define OSD_REG_NUMMOD    16'h0203
`define OSD_NUM_MODULES   16'd4

`endif

// File: osd_pkg.sv
`default_nettype none

package osd_pkg;

   typedef struct packed {
      logic        valid;
      logic        last;
      logic [15:0] data;
   } dii_flit;

   typedef enum logic [1:0] {
      SIZE_16 = 2'b01,
      SIZE_32 = 2'b10,
      SIZE_64 = 2'b11
   } osd_size_e;

   localparam logic [1:0] TYPE_REG = 2'b00;   // register access packet

   // second flit of a packet, request or response view
   typedef union packed {
      struct packed {
         logic [1:0] pkt_type;
         logic       burst;
         logic       write;
         osd_size_e  size;
         logic [9:0] src;
      } req;
      struct packed {
         logic [3:0] zero;
         logic       write;
         logic       error;
         logic [9:0] id;
      } resp;
   } osd_hdr_u;

   typedef struct packed {
      logic        write;
      logic [15:0] addr;
      osd_size_e   size;
      logic [15:0] wdata;
   } reg_req_t;

   typedef struct packed {
      logic        ack;
      logic        err;
      logic [15:0] rdata;
   } reg_rsp_t;

endpackage

`default_nettype wire

// File: osd_statctrlif.sv
`timescale 1ns/10ps
`default_nettype none

`include "osd_params.svh"

module osd_statctrlif (
   input  logic              clk,
   input  logic              rst,
   input  logic [9:0]        id,
   input  osd_pkg::dii_flit  debug_in,
   output logic              debug_in_ready,
   output osd_pkg::dii_flit  debug_out,
   input  logic              debug_out_ready,
   output logic              reg_request,
   output osd_pkg::reg_req_t reg_req,
   input  osd_pkg::reg_rsp_t reg_rsp,
   output logic              stall
);
   import osd_pkg::*;

   typedef enum logic [3:0] {
      ST_IDLE,
      ST_HDR,
      ST_ADDR,
      ST_WRITE,
      ST_EXT_DATA,
      ST_EXT_WAIT,
      ST_RESP_DEST,
      ST_RESP_HDR,
      ST_RESP_VALUE,
      ST_DROP
   } state_e;

   state_e      state, nxt_state;
   logic        stall_q, nxt_stall;
   osd_hdr_u    req_hdr, nxt_req_hdr;    // burst bit kept but not acted on
   logic [15:0] req_addr, nxt_req_addr;
   logic [15:0] value, nxt_value;        // write data out, read data back
   logic        resp_error, nxt_resp_error;
   osd_hdr_u    resp_hdr;
   logic        addr_is_ext;
   logic        local_wr_err;

   assign addr_is_ext = (debug_in.data >= `OSD_EXT_BASE);
   // only a 16 bit write to CS is a legal local write
   assign local_wr_err = (req_hdr.req.size != SIZE_16) || (debug_in.data != `OSD_REG_CS);

   assign stall = stall_q;

   assign reg_req.write = req_hdr.req.write;
   assign reg_req.addr  = req_addr;
   assign reg_req.size  = req_hdr.req.size;
   assign reg_req.wdata = value;

   always_comb begin
      resp_hdr            = '0;
      resp_hdr.resp.write = req_hdr.req.write;
      resp_hdr.resp.error = resp_error;
      resp_hdr.resp.id    = id;
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state   <= ST_IDLE;
         stall_q <= `OSD_CAN_STALL;
      end else begin
         state   <= nxt_state;
         stall_q <= nxt_stall;
      end
      req_hdr    <= nxt_req_hdr;
      req_addr   <= nxt_req_addr;
      value      <= nxt_value;
      resp_error <= nxt_resp_error;
   end

   always_comb begin
      nxt_state      = state;
      nxt_stall      = stall_q;
      nxt_req_hdr    = req_hdr;
      nxt_req_addr   = req_addr;
      nxt_value      = value;
      nxt_resp_error = resp_error;

      debug_in_ready = 1'b0;
      debug_out      = '0;
      reg_request    = 1'b0;

      case (state)
         ST_IDLE: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin   // destination flit, nothing to keep
               nxt_state = ST_HDR;
            end
         end
         ST_HDR: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               nxt_req_hdr    = debug_in.data;
               nxt_resp_error = 1'b0;
               if (debug_in.last) begin
                  nxt_state = ST_IDLE;
               end else if (debug_in.data[15:14] != TYPE_REG) begin
                  nxt_state = ST_DROP;
               end else begin
                  nxt_state = ST_ADDR;
               end
            end
         end
         ST_ADDR: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               nxt_req_addr = debug_in.data;
               if (req_hdr.req.write) begin
                  if (debug_in.last) begin
                     nxt_resp_error = 1'b1;   // data flit missing
                     nxt_state      = ST_RESP_DEST;
                  end else if (addr_is_ext) begin
                     nxt_state = ST_EXT_DATA;
                  end else begin
                     nxt_resp_error = local_wr_err;
                     nxt_state      = ST_WRITE;   // data flit is consumed either way
                  end
               end else if (!debug_in.last) begin
                  nxt_state = ST_DROP;   // read with trailing flits
               end else if (addr_is_ext) begin
                  nxt_state = ST_EXT_WAIT;
               end else begin
                  nxt_state = ST_RESP_DEST;
                  case (debug_in.data)
                     `OSD_REG_MODID:   nxt_value = `OSD_MODID;
                     `OSD_REG_VERSION: nxt_value = `OSD_MODVERSION;
                     default:          nxt_resp_error = 1'b1;
                  endcase
               end
            end
         end
         ST_WRITE: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               if ((debug_in.data[15:11] != `OSD_CS_STALL) || (`OSD_CAN_STALL == 1'b0)) begin
                  nxt_resp_error = 1'b1;
               end else if (!resp_error && debug_in.last) begin
                  nxt_stall = debug_in.data[0];
               end
               nxt_state = debug_in.last ? ST_RESP_DEST : ST_DROP;
            end
         end
         ST_EXT_DATA: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid) begin
               nxt_value = debug_in.data;
               nxt_state = debug_in.last ? ST_EXT_WAIT : ST_DROP;
            end
         end
         ST_EXT_WAIT: begin
            reg_request = 1'b1;   // held until the bank answers
            if (reg_rsp.ack || reg_rsp.err) begin
               nxt_resp_error = reg_rsp.err;
               if (!req_hdr.req.write) begin
                  nxt_value = reg_rsp.rdata;
               end
               nxt_state = ST_RESP_DEST;
            end
         end
         ST_RESP_DEST: begin
            debug_out.valid = 1'b1;
            debug_out.data  = {6'h0, req_hdr.req.src};
            if (debug_out_ready) begin
               nxt_state = ST_RESP_HDR;
            end
         end
         ST_RESP_HDR: begin
            debug_out.valid = 1'b1;
            debug_out.data  = resp_hdr;
            debug_out.last  = req_hdr.req.write || resp_error;   // no value flit
            if (debug_out_ready) begin
               nxt_state = debug_out.last ? ST_IDLE : ST_RESP_VALUE;
            end
         end
         ST_RESP_VALUE: begin
            debug_out.valid = 1'b1;
            debug_out.last  = 1'b1;
            debug_out.data  = value;
            if (debug_out_ready) begin
               nxt_state = ST_IDLE;
            end
         end
         ST_DROP: begin
            debug_in_ready = 1'b1;
            if (debug_in.valid && debug_in.last) begin
               nxt_state = ST_IDLE;
            end
         end
         default: begin
            nxt_state = ST_IDLE;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: osd_scm_regs.sv
`timescale 1ns/10ps
`default_nettype none

`include "osd_params.svh"

module osd_scm_regs (
   input  logic              clk,
   input  logic              rst,
   input  logic              reg_request,
   input  osd_pkg::reg_req_t reg_req,
   output osd_pkg::reg_rsp_t reg_rsp,
   output logic              sys_rst
);
   import osd_pkg::*;

   logic [15:0] scratch0;
   logic [15:0] scratch1;
   logic        sysrst_q;
   logic        answered;   // high in the ack or err cycle
   logic        err_q;
   logic [15:0] rdata_q;
   logic        dec_err;
   logic [15:0] dec_rdata;
   logic        new_req;

   // a request still held in the answer cycle is not taken again
   assign new_req = reg_request && !answered;

   always_comb begin
      dec_err   = 1'b0;
      dec_rdata = '0;
      case (reg_req.addr)
         `OSD_REG_SCRATCH0: dec_rdata = scratch0;
         `OSD_REG_SCRATCH1: dec_rdata = scratch1;
         `OSD_REG_SYSRST: begin
            dec_rdata = {15'h0, sysrst_q};
            dec_err   = reg_req.write && (reg_req.wdata[15:1] != '0);
         end
         `OSD_REG_NUMMOD: begin
            dec_rdata = `OSD_NUM_MODULES;
            dec_err   = reg_req.write;   // read only
         end
         default: dec_err = 1'b1;
      endcase
      if (reg_req.size != SIZE_16) begin
         dec_err = 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         answered <= 1'b0;
         scratch0 <= '0;
         scratch1 <= '0;
         sysrst_q <= 1'b0;
      end else begin
         answered <= new_req;
         if (new_req && reg_req.write && !dec_err) begin
            case (reg_req.addr)
               `OSD_REG_SCRATCH0: scratch0 <= reg_req.wdata;
               `OSD_REG_SCRATCH1: scratch1 <= reg_req.wdata;
               `OSD_REG_SYSRST:   sysrst_q <= reg_req.wdata[0];
               default:           sysrst_q <= sysrst_q;
            endcase
         end
      end
      err_q   <= dec_err;
      rdata_q <= dec_rdata;
   end

   assign reg_rsp.ack   = answered && !err_q;
   assign reg_rsp.err   = answered && err_q;
   assign reg_rsp.rdata = rdata_q;

   assign sys_rst = sysrst_q;

endmodule

`default_nettype wire

// File: osd_scm.sv
`timescale 1ns/10ps
`default_nettype none

module osd_scm (
   input  logic             clk,
   input  logic             rst,
   input  logic [9:0]       id,
   input  osd_pkg::dii_flit debug_in,
   output logic             debug_in_ready,
   output osd_pkg::dii_flit debug_out,
   input  logic             debug_out_ready,
   output logic             stall,
   output logic             sys_rst
);
   import osd_pkg::*;

   // register port between decoder and bank
   logic     reg_request;
   reg_req_t reg_req;
   reg_rsp_t reg_rsp;

   osd_statctrlif statctrlif_i (
      .clk             (clk),
      .rst             (rst),
      .id              (id),
      .debug_in        (debug_in),
      .debug_in_ready  (debug_in_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready),
      .reg_request     (reg_request),
      .reg_req         (reg_req),
      .reg_rsp         (reg_rsp),
      .stall           (stall)
   );

   osd_scm_regs regs_i (
      .clk         (clk),
      .rst         (rst),
      .reg_request (reg_request),
      .reg_req     (reg_req),
      .reg_rsp     (reg_rsp),
      .sys_rst     (sys_rst)
   );

endmodule

`default_nettype wire

// File: tb_osd_scm_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module handshake_checks (
   input logic              clk,
   input logic              rst,
   input osd_pkg::dii_flit  debug_out,
   input logic              debug_out_ready,
   input logic              reg_request,
   input osd_pkg::reg_rsp_t reg_rsp
);
   import osd_pkg::*;

   int fail_cnt = 0;

   // a flit that is offered stays put until it is taken
   out_stable: assert property (@(posedge clk) disable iff (rst)
      debug_out.valid && !debug_out_ready |=> $stable(debug_out))
      else begin
         $error("debug_out changed while valid and not accepted");
         fail_cnt++;
      end

   req_held: assert property (@(posedge clk) disable iff (rst)
      reg_request && !(reg_rsp.ack || reg_rsp.err) |=> reg_request)
      else begin
         $error("reg_request dropped before ack or err");
         fail_cnt++;
      end

   // one answer, either ack or err, one cycle after the request and for one cycle
   rsp_one_cycle: assert property (@(posedge clk) disable iff (rst)
      $rose(reg_request) |=> (reg_rsp.ack ^ reg_rsp.err) ##1 !(reg_rsp.ack || reg_rsp.err))
      else begin
         $error("no single one cycle ack or err in the cycle after reg_request");
         fail_cnt++;
      end

endmodule

bind osd_statctrlif handshake_checks checks_i (
   .clk             (clk),
   .rst             (rst),
   .debug_out       (debug_out),
   .debug_out_ready (debug_out_ready),
   .reg_request     (reg_request),
   .reg_rsp         (reg_rsp)
);

`default_nettype wire

// File: tb_osd_scm.sv
`timescale 1ns/10ps
`default_nettype none

`include "osd_params.svh"

module tb_osd_scm;
   import osd_pkg::*;

   localparam int NUM_DIRECTED = 27;
   localparam int NUM_RANDOM   = 40;
   localparam int NUM_PKTS     = NUM_DIRECTED + NUM_RANDOM;
   localparam logic [9:0] DUT_ID = 10'h3c1;
   localparam logic [9:0] SRC_ID = 10'h0a5;

   typedef struct packed {
      dii_flit    f0;
      dii_flit    f1;
      dii_flit    f2;
      logic [1:0] n;        // flits in the packet, 0 when none is due
      logic       stall;
      logic       sys_rst;
   } rsp_t;

   logic    clk;
   logic    rst;
   dii_flit debug_in;
   logic    debug_in_ready;
   dii_flit debug_out;
   logic    debug_out_ready;
   logic    stall;
   logic    sys_rst;

   logic [31:0] lfsr_q = 32'h8c69;
   logic        jitter = 1'b0;      // random gaps and back-pressure
   rsp_t        exp_q[$];
   rsp_t        got_q[$];
   rsp_t        cur_rsp = '0;
   int          flit_cnt = 0;
   int          n_expected = 0;
   int          n_checked = 0;

   // register model
   logic        m_stall = `OSD_CAN_STALL;
   logic        m_sysrst = 1'b0;
   logic [15:0] m_scratch0 = '0;
   logic [15:0] m_scratch1 = '0;

   osd_scm dut_i (
      .clk             (clk),
      .rst             (rst),
      .id              (DUT_ID),
      .debug_in        (debug_in),
      .debug_in_ready  (debug_in_ready),
      .debug_out       (debug_out),
      .debug_out_ready (debug_out_ready),
      .stall           (stall),
      .sys_rst         (sys_rst)
   );

   always #4 clk = ~clk;

   function automatic logic rand_bit();
      logic out;
      out = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (out) begin
         lfsr_q = lfsr_q ^ 32'h8020_0003;
      end
      return out;
   endfunction

   function automatic logic [15:0] rand_bits(input int n);
      logic [15:0] v;
      int          i;
      v = '0;
      for (i = 0; i < n; i++) begin
         v = {v[14:0], rand_bit()};
      end
      return v;
   endfunction

   // expected response from the request alone, updates the model
   function automatic rsp_t expect_response(input logic [1:0] ptype, input logic write,
                                            input osd_size_e size, input logic [15:0] addr,
                                            input logic [15:0] wdata, input int n_tail);
      rsp_t        r;
      osd_hdr_u    h;
      logic        err;
      logic [15:0] val;
      r   = '0;
      err = 1'b0;
      val = '0;
      if (ptype != TYPE_REG || (write && n_tail > 1) || (!write && n_tail != 0)) begin
         return r;   // dropped
      end
      if (write && n_tail == 0) begin
         err = 1'b1;
      end else if (addr >= `OSD_EXT_BASE) begin
         err = (size != SIZE_16);
         case (addr)
            `OSD_REG_SCRATCH0: val = m_scratch0;
            `OSD_REG_SCRATCH1: val = m_scratch1;
            `OSD_REG_SYSRST: begin
               val = {15'h0, m_sysrst};
               err = err || (write && wdata[15:1] != '0);
            end
            `OSD_REG_NUMMOD: begin
               val = `OSD_NUM_MODULES;
               err = err || write;
            end
            default: err = 1'b1;
         endcase
         if (write && !err) begin
            case (addr)
               `OSD_REG_SCRATCH0: m_scratch0 = wdata;
               `OSD_REG_SCRATCH1: m_scratch1 = wdata;
               default:           m_sysrst = wdata[0];
            endcase
         end
      end else if (write) begin
         err = (size != SIZE_16) || (addr != `OSD_REG_CS) ||
               (wdata[15:11] != `OSD_CS_STALL) || !`OSD_CAN_STALL;
         if (!err) begin
            m_stall = wdata[0];
         end
      end else if (addr == `OSD_REG_MODID) begin
         val = `OSD_MODID;
      end else if (addr == `OSD_REG_VERSION) begin
         val = `OSD_MODVERSION;
      end else begin
         err = 1'b1;
      end
      h            = '0;
      h.resp.write = write;
      h.resp.error = err;
      h.resp.id    = DUT_ID;
      r.f0.valid = 1'b1;
      r.f0.data  = {6'h0, SRC_ID};
      r.f1.valid = 1'b1;
      r.f1.last  = write || err;
      r.f1.data  = h;
      r.n        = 2'd2;
      if (!write && !err) begin
         r.f2.valid = 1'b1;
         r.f2.last  = 1'b1;
         r.f2.data  = val;
         r.n        = 2'd3;
      end
      r.stall   = m_stall;
      r.sys_rst = m_sysrst;
      return r;
   endfunction

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1);
   endtask

   task automatic compare_flit(input string name, input dii_flit got, input dii_flit exp);
      if (got !== exp) begin
         stop_run($sformatf("ERROR at %0t: %s = %h, expected %h", $time, name, got, exp));
      end
   endtask

   task automatic compare_hdr(input string name, input osd_hdr_u got, input osd_hdr_u exp);
      if (got !== exp) begin
         stop_run($sformatf("ERROR at %0t: %s = %h (write %b error %b id %h), %s",
                            $time, name, got, got.resp.write, got.resp.error, got.resp.id,
                            $sformatf("expected %h (write %b error %b id %h)",
                                      exp, exp.resp.write, exp.resp.error, exp.resp.id)));
      end
   endtask

   task automatic compare_bit(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         stop_run($sformatf("ERROR at %0t: %s = %b, expected %b", $time, name, got, exp));
      end
   endtask

   // called at posedge + 1, returns at posedge + 1 after the flit is taken
   task automatic send_flit(input logic [15:0] data, input logic last);
      logic acc;
      acc = 1'b0;
      while (jitter && rand_bit() && rand_bit()) begin
         debug_in = '0;
         @(posedge clk);
         #1;
      end
      debug_in.valid = 1'b1;
      debug_in.last  = last;
      debug_in.data  = data;
      while (!acc) begin
         @(negedge clk);
         acc = debug_in_ready;
         @(posedge clk);
         #1;
      end
      debug_in = '0;
   endtask

   task automatic send_packet(input logic [1:0] ptype, input logic write, input osd_size_e size,
                              input logic [15:0] addr, input logic [15:0] wdata, input int n_tail);
      osd_hdr_u hdr;
      rsp_t     exp;
      int       i;
      exp = expect_response(ptype, write, size, addr, wdata, n_tail);
      if (exp.n != 0) begin
         exp_q.push_back(exp);
         n_expected++;
      end
      hdr          = '0;
      hdr.req.pkt_type = ptype;
      hdr.req.write    = write;
      hdr.req.size     = size;
      hdr.req.src      = SRC_ID;
      send_flit(16'h0001, 1'b0);   // destination
      send_flit(hdr, 1'b0);
      send_flit(addr, n_tail == 0);
      for (i = 0; i < n_tail; i++) begin
         send_flit((i == 0) ? wdata : 16'hd0d0 + 16'(i), i == n_tail - 1);
      end
   endtask

   task automatic random_packet();
      logic [2:0]  pick;
      logic        write;
      logic [15:0] wdata;
      logic [15:0] addr;
      pick  = rand_bits(3);
      write = rand_bit();
      wdata = rand_bits(16);
      case (pick)
         3'd0:    addr = `OSD_REG_MODID;
         3'd1:    addr = `OSD_REG_VERSION;
         3'd2:    addr = `OSD_REG_CS;
         3'd3:    addr = `OSD_REG_SCRATCH0;
         3'd4:    addr = `OSD_REG_SCRATCH1;
         3'd5:    addr = `OSD_REG_SYSRST;
         3'd6:    addr = `OSD_REG_NUMMOD;
         default: addr = 16'h0002;
      endcase
      if (addr == `OSD_REG_CS) begin
         wdata = {`OSD_CS_STALL, 10'h0, wdata[0]};
      end
      if (addr == `OSD_REG_SYSRST && wdata[8]) begin
         wdata[15:1] = '0;   // mostly legal sysrst writes
      end
      send_packet(TYPE_REG, write, SIZE_16, addr, wdata, write ? 1 : 0);
   endtask

   always @(posedge clk) begin
      #1;
      debug_out_ready = jitter ? (rand_bit() | rand_bit()) : 1'b1;
   end

   // response collector, sampled mid cycle
   always @(negedge clk) begin
      if (!rst && debug_out.valid) begin
         compare_bit("debug_in_ready", debug_in_ready, 1'b0);   // input held off while answering
      end
      if (!rst && debug_out.valid && debug_out_ready) begin
         case (flit_cnt)
            0:       cur_rsp.f0 = debug_out;
            1:       cur_rsp.f1 = debug_out;
            2:       cur_rsp.f2 = debug_out;
            default: stop_run("response packet longer than three flits");
         endcase
         flit_cnt++;
         if (debug_out.last) begin
            cur_rsp.n       = flit_cnt;
            cur_rsp.stall   = stall;
            cur_rsp.sys_rst = sys_rst;
            got_q.push_back(cur_rsp);
            cur_rsp  = '0;
            flit_cnt = 0;
         end
      end
   end

   initial begin
      rsp_t got;
      rsp_t exp;
      forever begin
         @(posedge clk);
         while (got_q.size() != 0) begin
            got = got_q.pop_front();
            if (exp_q.size() == 0) begin
               stop_run("a response arrived for a packet that should have been dropped");
            end
            exp = exp_q.pop_front();
            compare_flit("debug_out destination", got.f0, exp.f0);
            compare_hdr("response header", got.f1.data, exp.f1.data);
            compare_flit("debug_out header", got.f1, exp.f1);
            if (got.n != exp.n) begin
               stop_run($sformatf("ERROR at %0t: response flit count = %0d, expected %0d",
                                  $time, got.n, exp.n));
            end
            if (exp.n == 2'd3) begin
               compare_flit("debug_out value", got.f2, exp.f2);
            end
            compare_bit("stall", got.stall, exp.stall);
            compare_bit("sys_rst", got.sys_rst, exp.sys_rst);
            n_checked++;
         end
      end
   end

   initial begin
      repeat (NUM_PKTS * 40) @(posedge clk);
      stop_run($sformatf("timeout after %0d cycles, responses stopped arriving", NUM_PKTS * 40));
   end

   initial begin
      clk             = 1'b0;
      rst             = 1'b1;
      debug_in        = '0;
      debug_out_ready = 1'b1;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
      compare_bit("stall", stall, `OSD_CAN_STALL);
      compare_bit("sys_rst", sys_rst, 1'b0);
      compare_bit("debug_in_ready", debug_in_ready, 1'b1);

      send_packet(TYPE_REG, 1'b0, SIZE_16, `OSD_REG_MODID, 16'h0, 0);
      send_packet(TYPE_REG, 1'b0, SIZE_16, `OSD_REG_VERSION, 16'h0, 0);
      send_packet(TYPE_REG, 1'b0, SIZE_16, 16'h0002, 16'h0, 0);

      // stall command, then the rejected forms
      send_packet(TYPE_REG, 1'b1, SIZE_16, `OSD_REG_CS, 16'h0800, 1);
      send_packet(TYPE_REG, 1'b1, SIZE_16, `OSD_REG_CS, 16'h0801, 1);
      send_packet(TYPE_REG, 1'b1, SIZE_16, `OSD_REG_CS, 16'h0800, 1);
      send_packet(TYPE_REG, 1'b1, SIZE_16, `OSD_REG_CS, 16'h1001, 1);   // command 2
      send_packet(TYPE_REG, 1'b1, SIZE_32, `OSD_REG_CS, 16'h0801, 1);
      send_packet(TYPE_REG, 1'b1, SIZE_16, `OSD_REG_CS, 16'h0801, 0);   // no data flit

      send_packet(TYPE_REG, 1'b1, SIZE_16, `OSD_REG_SCRATCH0, rand_bits(16), 1);
      send_packet(TYPE_REG, 1'b1, SIZE_16, `OSD_REG_SCRATCH1, rand_bits(16), 1);
      send_packet(TYPE_REG, 1'b0, SIZE_16, `OSD_REG_SCRATCH0, 16'h0, 0);
      send_packet(TYPE_REG, 1'b0, SIZE_16, `OSD_REG_SCRATCH1, 16'h0, 0);
      send_packet(TYPE_REG, 1'b1, SIZE_16, `OSD_REG_SYSRST, 16'h0001, 1);
      send_packet(TYPE_REG, 1'b0, SIZE_16, `OSD_REG_SYSRST, 16'h0, 0);
      send_packet(TYPE_REG, 1'b0, SIZE_16, `OSD_REG_NUMMOD, 16'h0, 0);
      send_packet(TYPE_REG, 1'b1, SIZE_16, `OSD_REG_SYSRST, 16'h0000, 1);
      send_packet(TYPE_REG, 1'b0, SIZE_16, `OSD_REG_SYSRST, 16'h0, 0);

      // bank errors
      send_packet(TYPE_REG, 1'b0, SIZE_16, 16'h0210, 16'h0, 0);
      send_packet(TYPE_REG, 1'b1, SIZE_16, 16'h0210, 16'h1234, 1);
      send_packet(TYPE_REG, 1'b1, SIZE_16, `OSD_REG_NUMMOD, 16'h0005, 1);
      send_packet(TYPE_REG, 1'b1, SIZE_16, `OSD_REG_SYSRST, 16'h8001, 1);
      send_packet(TYPE_REG, 1'b0, SIZE_16, `OSD_REG_SYSRST, 16'h0, 0);
      send_packet(TYPE_REG, 1'b0, SIZE_16, `OSD_REG_SCRATCH1, 16'h0, 0);

      // silently dropped packets
      send_packet(2'b01, 1'b1, SIZE_16, `OSD_REG_SCRATCH0, 16'hbeef, 1);
      send_packet(TYPE_REG, 1'b0, SIZE_16, `OSD_REG_MODID, 16'h0, 2);
      send_packet(TYPE_REG, 1'b0, SIZE_16, `OSD_REG_SCRATCH0, 16'h0, 0);

      jitter = 1'b1;
      repeat (NUM_RANDOM) random_packet();
      jitter = 1'b0;

      while (n_checked != n_expected) begin
         @(posedge clk);
      end
      repeat (20) @(posedge clk);   // room for a stray response
      if (dut_i.statctrlif_i.checks_i.fail_cnt != 0) begin
         stop_run("a handshake assertion failed during the run");
      end else begin
         $display("=== PASS ===");
         $finish;
      end
   end

endmodule

`default_nettype wire

// File: src.f
+incdir+.
osd_pkg.sv
osd_statctrlif.sv
osd_scm_regs.sv
osd_scm.sv
tb_osd_scm_assertions.sv
tb_osd_scm.sv
